//--- include/cap_cfg.svh
`ifndef CAP_CFG_SVH
`define CAP_CFG_SVH

// FIFO geometry
// Address bits, depth is 2**AW
`define CAP_FIFO_AW   4

// Sample fields
`define CAP_SAMPLE_W  16
`define CAP_CHAN_W    3

// Marker fields
`define CAP_SEQ_W     7
`define CAP_STAMP_W   12

// One FIFO word, kind bit plus the larger record body
`define CAP_WORD_W    20

// Programmed sample count
`define CAP_CNT_W     8

`endif

//--- src/cap_pkg.sv
`include "cap_cfg.svh"

package cap_pkg;

    // ------------------------------------------------------------------------
    // Incoming sample, wclk domain
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [`CAP_CHAN_W-1:0]   chan;
        logic [`CAP_SAMPLE_W-1:0] value;
    } sample_in_s;

    // ------------------------------------------------------------------------
    // FIFO records, bit 19 is kind in both
    // ------------------------------------------------------------------------

    // Sample record, kind 0
    typedef struct packed {
        logic                     kind;
        logic [`CAP_CHAN_W-1:0]   chan;
        logic [`CAP_SAMPLE_W-1:0] value;
    } sample_rec_s;

    // Marker record, kind 1
    // One per capture, written at the trigger edge
    typedef struct packed {
        logic                    kind;
        logic [`CAP_SEQ_W-1:0]   seq;
        logic [`CAP_STAMP_W-1:0] stamp;
    } marker_rec_s;

    // Same 20 bits seen either way
    // Host picks the view from kind
    typedef union packed {
        sample_rec_s sample;
        marker_rec_s marker;
    } fifo_word_u;

endpackage

//--- src/reg_pkg.sv
`include "cap_cfg.svh"

package reg_pkg;

    // ------------------------------------------------------------------------
    // Host bus, plain strobes in the rclk domain
    // ------------------------------------------------------------------------

    typedef struct packed {
        logic [1:0]             addr;
        logic                   wr;
        logic                   rd;
        logic [`CAP_WORD_W-1:0] wdata;
    } host_req_s;

    // CTRL register, arm at bit 8, count in 7:0
    typedef struct packed {
        logic                  arm;
        logic [`CAP_CNT_W-1:0] count;
    } ctrl_s;

    // STATUS word, empty at bit 2 down to overflow at bit 0
    typedef struct packed {
        logic empty;
        logic done;
        logic overflow;
    } status_s;

    // Register map
    localparam logic [1:0] REG_CTRL   = 2'd0;
    localparam logic [1:0] REG_STATUS = 2'd1;
    localparam logic [1:0] REG_DATA   = 2'd2;

endpackage

//--- src/fifo_wptr_full.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module fifo_wptr_full #(
    parameter int ADDR_W = `CAP_FIFO_AW
) (
    input  logic              wclk,
    input  logic              rrst_n,
    input  logic              winc,
    input  logic [ADDR_W:0]   rptr,
    output logic [ADDR_W-1:0] waddr,
    output logic [ADDR_W:0]   wptr,
    output logic              wfull
);

    logic [ADDR_W:0] wbin;
    logic [ADDR_W:0] wbin_next;
    logic [ADDR_W:0] wgray_next;
    // Read pointer after two wclk flops
    logic [ADDR_W:0] rptr_q1;
    logic [ADDR_W:0] rptr_q2;
    logic            wfull_next;

    // ------------------------------------------------------------------------
    // Read pointer into the write domain
    // ------------------------------------------------------------------------

    always_ff @(posedge wclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rptr_q1 <= '0;
            rptr_q2 <= '0;
        end else begin
            rptr_q1 <= rptr;
            rptr_q2 <= rptr_q1;
        end
    end

    // Advance only on an accepted write
    assign wbin_next  = wbin + {{ADDR_W{1'b0}}, winc && !wfull};
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    // Full when writer is one lap ahead, top two Gray bits differ
    assign wfull_next = (wgray_next == {~rptr_q2[ADDR_W:ADDR_W-1], rptr_q2[ADDR_W-2:0]});

    always_ff @(posedge wclk or negedge rrst_n) begin
        if (!rrst_n) begin
            wbin  <= '0;
            wptr  <= '0;
            wfull <= 1'b0;
        end else begin
            wbin  <= wbin_next;
            wptr  <= wgray_next;
            wfull <= wfull_next;
        end
    end

    // Memory addressed in binary
    assign waddr = wbin[ADDR_W-1:0];

    // Pointer frozen once full is seen
    assert property (@(posedge wclk) disable iff (!rrst_n) wfull |=> $stable(wptr));

    // Gray code toward the read side, one bit per edge at most
    assert property (@(posedge wclk) disable iff (!rrst_n) $onehot0(wptr ^ $past(wptr)));

endmodule

//--- src/fifo_rptr_empty.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module fifo_rptr_empty #(
    parameter int ADDR_W = `CAP_FIFO_AW
) (
    input  logic              rclk,
    input  logic              rrst_n,
    input  logic              rinc,
    input  logic [ADDR_W:0]   wptr,
    output logic [ADDR_W-1:0] raddr,
    output logic [ADDR_W:0]   rptr,
    output logic              rempty
);

    logic [ADDR_W:0] rbin;
    logic [ADDR_W:0] rbin_next;
    logic [ADDR_W:0] rgray_next;
    // Write pointer after two rclk flops
    logic [ADDR_W:0] wptr_q1;
    logic [ADDR_W:0] wptr_q2;
    logic            rempty_next;

    // ------------------------------------------------------------------------
    // Write pointer into the read domain
    // ------------------------------------------------------------------------

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            wptr_q1 <= '0;
            wptr_q2 <= '0;
        end else begin
            wptr_q1 <= wptr;
            wptr_q2 <= wptr_q1;
        end
    end

    // Pop moves the pointer unless empty
    assign rbin_next  = rbin + {{ADDR_W{1'b0}}, rinc && !rempty};
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // Caught up with the writer
    assign rempty_next = (rgray_next == wptr_q2);

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            rbin   <= '0;
            rptr   <= '0;
            rempty <= 1'b1;
        end else begin
            rbin   <= rbin_next;
            rptr   <= rgray_next;
            rempty <= rempty_next;
        end
    end

    assign raddr = rbin[ADDR_W-1:0];

    // Empty holds the read pointer
    assert property (@(posedge rclk) disable iff (!rrst_n) rempty |=> $stable(rptr));

endmodule

//--- src/fifo_async.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module fifo_async #(
    parameter int ADDR_W = `CAP_FIFO_AW
) (
    input  logic                wclk,
    input  logic                rclk,
    input  logic                rrst_n,
    input  logic                winc,
    input  logic                rinc,
    input  cap_pkg::fifo_word_u wdata,
    output cap_pkg::fifo_word_u rdata,
    output logic                wfull,
    output logic                rempty
);

    localparam int DEPTH = 1 << ADDR_W;

    logic [ADDR_W-1:0] waddr;
    logic [ADDR_W-1:0] raddr;
    // Gray pointers crossing between domains
    logic [ADDR_W:0]   wptr;
    logic [ADDR_W:0]   rptr;

    // Storage, written in wclk
    cap_pkg::fifo_word_u mem [DEPTH];

    // ------------------------------------------------------------------------
    // Memory
    // ------------------------------------------------------------------------

    // Writes while full are dropped here
    always_ff @(posedge wclk) begin
        if (winc && !wfull) begin
            mem[waddr] <= wdata;
        end
    end

    // Head word, read without a clock
    assign rdata = mem[raddr];

    // ------------------------------------------------------------------------
    // Pointer blocks
    // ------------------------------------------------------------------------

    fifo_wptr_full #(
        .ADDR_W (ADDR_W)
    ) u_wptr_full (
        .wclk   (wclk),
        .rrst_n (rrst_n),
        .winc   (winc),
        .rptr   (rptr),
        .waddr  (waddr),
        .wptr   (wptr),
        .wfull  (wfull)
    );

    fifo_rptr_empty #(
        .ADDR_W (ADDR_W)
    ) u_rptr_empty (
        .rclk   (rclk),
        .rrst_n (rrst_n),
        .rinc   (rinc),
        .wptr   (wptr),
        .raddr  (raddr),
        .rptr   (rptr),
        .rempty (rempty)
    );

endmodule

//--- src/capture_ctrl.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module capture_ctrl (
    input  logic                 wclk,
    input  logic                 rrst_n,
    input  cap_pkg::sample_in_s  sample,
    input  logic                 sample_valid,
    input  logic                 trig,
    input  reg_pkg::ctrl_s       ctrl,
    input  logic                 wfull,
    output cap_pkg::fifo_word_u  wdata,
    output logic                 winc,
    output logic                 done,
    output logic                 overflow
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WAIT,
        ST_CAPTURE
    } state_e;

    state_e                  state;
    // Two sync flops plus one of history for the edge
    logic [2:0]              arm_sync;
    logic                    arm_rise;
    logic                    trig_d;
    logic                    trig_rise;
    logic                    mark_wr;
    logic                    samp_wr;
    logic [`CAP_CNT_W-1:0]   remain;
    logic [`CAP_SEQ_W-1:0]   seq;
    logic [`CAP_STAMP_W-1:0] stamp;
    // Delay from last write to done
    logic [2:0]              drain;

    // ------------------------------------------------------------------------
    // Edge detection
    // ------------------------------------------------------------------------

    // arm is a quasi-static level from rclk
    // count is only sampled on the arm edge
    always_ff @(posedge wclk or negedge rrst_n) begin
        if (!rrst_n) begin
            arm_sync <= '0;
            trig_d   <= 1'b0;
        end else begin
            arm_sync <= {arm_sync[1:0], ctrl.arm};
            trig_d   <= trig;
        end
    end

    assign arm_rise  = arm_sync[1] && !arm_sync[2];
    assign trig_rise = trig && !trig_d;

    // Free-running timestamp, wraps
    always_ff @(posedge wclk or negedge rrst_n) begin
        if (!rrst_n) begin
            stamp <= '0;
        end else begin
            stamp <= stamp + 1'b1;
        end
    end

    // Write requests for this cycle
    assign mark_wr = (state == ST_WAIT) && trig_rise;
    assign samp_wr = (state == ST_CAPTURE) && sample_valid;

    // ------------------------------------------------------------------------
    // FSM and counters
    // ------------------------------------------------------------------------

    always_ff @(posedge wclk or negedge rrst_n) begin
        if (!rrst_n) begin
            state    <= ST_IDLE;
            remain   <= '0;
            seq      <= '0;
            winc     <= 1'b0;
            drain    <= '0;
            done     <= 1'b0;
            overflow <= 1'b0;
        end else begin
            winc  <= !arm_rise && (mark_wr || samp_wr);
            drain <= {drain[1:0], 1'b0};
            // done waits until the last word can be seen on the read side
            if (drain[2]) begin
                done <= 1'b1;
            end
            // Word dropped by a full FIFO, sticky
            if (winc && wfull) begin
                overflow <= 1'b1;
            end
            if (arm_rise) begin
                state    <= ST_WAIT;
                remain   <= ctrl.count;
                drain    <= '0;
                done     <= 1'b0;
                overflow <= 1'b0;
            end else begin
                case (state)
                    ST_WAIT: begin
                        if (trig_rise) begin
                            seq <= seq + 1'b1;
                            // Count of zero is a marker-only capture
                            if (remain == '0) begin
                                state    <= ST_IDLE;
                                drain[0] <= 1'b1;
                            end else begin
                                state <= ST_CAPTURE;
                            end
                        end
                    end
                    ST_CAPTURE: begin
                        if (sample_valid) begin
                            remain <= remain - 1'b1;
                            if (remain == `CAP_CNT_W'(1)) begin
                                state    <= ST_IDLE;
                                drain[0] <= 1'b1;
                            end
                        end
                    end
                    default: begin
                        state <= ST_IDLE;
                    end
                endcase
            end
        end
    end

    // Word payload, filled through one view of the union
    always_ff @(posedge wclk) begin
        if (mark_wr) begin
            wdata.marker.kind  <= 1'b1;
            wdata.marker.seq   <= seq;
            wdata.marker.stamp <= stamp;
        end else if (samp_wr) begin
            wdata.sample.kind  <= 1'b0;
            wdata.sample.chan  <= sample.chan;
            wdata.sample.value <= sample.value;
        end
    end

    // Marker writes come only from a trigger seen in WAIT
    assert property (@(posedge wclk) disable iff (!rrst_n)
        (winc && wdata.marker.kind) |-> $past(state == ST_WAIT));

    // No write request raised while idle
    assert property (@(posedge wclk) disable iff (!rrst_n)
        winc |-> $past(state != ST_IDLE));

endmodule

//--- src/host_regs.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module host_regs (
    input  logic                   rclk,
    input  logic                   rrst_n,
    input  reg_pkg::host_req_s     host_req,
    output logic [`CAP_WORD_W-1:0] host_rdata,
    output reg_pkg::ctrl_s         ctrl,
    input  cap_pkg::fifo_word_u    rdata,
    input  logic                   rempty,
    output logic                   rinc,
    input  logic                   done,
    input  logic                   overflow
);

    // Status levels from wclk through two flops each
    logic [1:0]       done_sync;
    logic [1:0]       ovf_sync;
    reg_pkg::status_s status;
    logic             wr_ctrl;
    logic             rd_data;

    // ------------------------------------------------------------------------
    // Decode
    // ------------------------------------------------------------------------

    assign wr_ctrl = host_req.wr && (host_req.addr == reg_pkg::REG_CTRL);
    assign rd_data = host_req.rd && (host_req.addr == reg_pkg::REG_DATA);

    // Pop in the same cycle as the DATA read
    assign rinc = rd_data && !rempty;

    // CTRL
    // Host writes count first and raises arm later
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            ctrl <= '0;
        end else if (wr_ctrl) begin
            ctrl <= reg_pkg::ctrl_s'(host_req.wdata[$bits(reg_pkg::ctrl_s)-1:0]);
        end
    end

    // ------------------------------------------------------------------------
    // Status synchronizers
    // ------------------------------------------------------------------------

    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            done_sync <= '0;
            ovf_sync  <= '0;
        end else begin
            done_sync <= {done_sync[0], done};
            ovf_sync  <= {ovf_sync[0], overflow};
        end
    end

    // empty is already in rclk
    assign status = '{empty: rempty, done: done_sync[1], overflow: ovf_sync[1]};

    // ------------------------------------------------------------------------
    // Read mux
    // ------------------------------------------------------------------------

    // Registered and held until the next read
    always_ff @(posedge rclk or negedge rrst_n) begin
        if (!rrst_n) begin
            host_rdata <= '0;
        end else if (host_req.rd) begin
            case (host_req.addr)
                reg_pkg::REG_CTRL: begin
                    host_rdata <= `CAP_WORD_W'(ctrl);
                end
                reg_pkg::REG_STATUS: begin
                    host_rdata <= `CAP_WORD_W'(status);
                end
                reg_pkg::REG_DATA: begin
                    // Empty FIFO reads as zero
                    host_rdata <= rempty ? '0 : rdata;
                end
                default: begin
                    host_rdata <= '0;
                end
            endcase
        end
    end

    // A word at the head stays there until it is popped
    assert property (@(posedge rclk) disable iff (!rrst_n) (!rempty && !rinc) |=> !rempty);

endmodule

//--- src/capture_top.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module capture_top (
    input  logic                   wclk,
    input  logic                   rclk,
    input  logic                   rrst_n,
    input  cap_pkg::sample_in_s    sample,
    input  logic                   sample_valid,
    input  logic                   trig,
    input  reg_pkg::host_req_s     host_req,
    output logic [`CAP_WORD_W-1:0] host_rdata
);

    // rclk to wclk, quasi-static
    reg_pkg::ctrl_s      ctrl;
    // wclk side of the FIFO
    cap_pkg::fifo_word_u wdata;
    logic                winc;
    logic                wfull;
    // rclk side of the FIFO
    cap_pkg::fifo_word_u rdata;
    logic                rinc;
    logic                rempty;
    // wclk levels into STATUS
    logic                done;
    logic                overflow;

    host_regs u_host_regs (
        .rclk       (rclk),
        .rrst_n     (rrst_n),
        .host_req   (host_req),
        .host_rdata (host_rdata),
        .ctrl       (ctrl),
        .rdata      (rdata),
        .rempty     (rempty),
        .rinc       (rinc),
        .done       (done),
        .overflow   (overflow)
    );

    capture_ctrl u_capture_ctrl (
        .wclk         (wclk),
        .rrst_n       (rrst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .trig         (trig),
        .ctrl         (ctrl),
        .wfull        (wfull),
        .wdata        (wdata),
        .winc         (winc),
        .done         (done),
        .overflow     (overflow)
    );

    fifo_async #(
        .ADDR_W (`CAP_FIFO_AW)
    ) u_fifo_async (
        .wclk   (wclk),
        .rclk   (rclk),
        .rrst_n (rrst_n),
        .winc   (winc),
        .rinc   (rinc),
        .wdata  (wdata),
        .rdata  (rdata),
        .wfull  (wfull),
        .rempty (rempty)
    );

endmodule

//--- bench/capture_tb.sv
`timescale 1ns/10ps
`include "cap_cfg.svh"

module capture_tb;

    localparam int N_ROWS      = 6;
    localparam int CYCLE_LIMIT = N_ROWS * 400;
    localparam int DEPTH       = 1 << `CAP_FIFO_AW;

    // One scenario: count, pre-trigger samples, offered samples, valid mask, re-arm
    typedef struct packed {
        logic [7:0] count;
        logic [7:0] pre;
        logic [7:0] post;
        logic [7:0] gap;
        logic       rearm;
    } row_s;

    logic                   wclk;
    logic                   rclk;
    logic                   rrst_n;
    cap_pkg::sample_in_s    sample;
    logic                   sample_valid;
    logic                   trig;
    reg_pkg::host_req_s     host_req;
    logic [`CAP_WORD_W-1:0] host_rdata;

    row_s                   rows [N_ROWS];
    logic [31:0]            seed;
    int                     val_errors;
    int                     other_errors;
    int                     cycles;
    // Reference stream for the current row
    logic [`CAP_WORD_W-1:0] exp_q [$];
    logic                   exp_ovf;
    logic [`CAP_SEQ_W-1:0]  exp_seq;
    logic [`CAP_WORD_W-1:0] rd;
    int                     r;

    capture_top UUT (
        .wclk         (wclk),
        .rclk         (rclk),
        .rrst_n       (rrst_n),
        .sample       (sample),
        .sample_valid (sample_valid),
        .trig         (trig),
        .host_req     (host_req),
        .host_rdata   (host_rdata)
    );

    // ------------------------------------------------------------------------
    // Clocks, unrelated periods
    // ------------------------------------------------------------------------

    initial begin
        wclk = 1'b0;
        forever #5 wclk = ~wclk;
    end

    initial begin
        rclk = 1'b0;
        forever #7 rclk = ~rclk;
    end

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------

    function automatic logic [31:0] next_rand(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic check_value(input string name, input logic [19:0] got,
                               input logic [19:0] exp, input logic [19:0] mask);
        assert ((got & mask) == (exp & mask)) else begin
            val_errors++;
            $display("** Error: %s got %h expected %h", name, got & mask, exp & mask);
        end
    endtask

    // Write takes effect on the edge after it is driven
    task automatic host_write(input logic [1:0] addr, input logic [19:0] data);
        @(posedge rclk);
        host_req <= '{addr: addr, wr: 1'b1, rd: 1'b0, wdata: data};
        @(posedge rclk);
        host_req <= '0;
    endtask

    // Data is registered on the edge after rd, sampled mid-cycle
    task automatic host_read(input logic [1:0] addr, output logic [19:0] data);
        @(posedge rclk);
        host_req <= '{addr: addr, wr: 1'b0, rd: 1'b1, wdata: '0};
        @(posedge rclk);
        host_req <= '0;
        @(negedge rclk);
        data = host_rdata;
    endtask

    task automatic offer_sample(input logic valid, output cap_pkg::sample_in_s s);
        @(posedge wclk);
        seed = next_rand(seed);
        s.chan  = seed[14:12];
        s.value = seed[31:16];
        sample       <= s;
        sample_valid <= valid;
    endtask

    // ------------------------------------------------------------------------
    // One scenario row
    // ------------------------------------------------------------------------

    task automatic run_row(input row_s rw);
        reg_pkg::ctrl_s      c;
        cap_pkg::sample_in_s s;
        cap_pkg::fifo_word_u w;
        reg_pkg::status_s    st;
        logic [19:0]         d;
        logic                valid;
        int                  i;
        int                  stored;
        int                  n_read;
        exp_q.delete();
        c.count = rw.count;
        c.arm   = 1'b0;
        if (rw.rearm) begin
            // Count goes in with arm low, arm rises later
            host_write(reg_pkg::REG_CTRL, {11'b0, c});
            repeat (4) @(posedge wclk);
            c.arm = 1'b1;
            host_write(reg_pkg::REG_CTRL, {11'b0, c});
            repeat (8) @(posedge wclk);
            exp_ovf = 1'b0;
            w = '0;
            w.marker.kind = 1'b1;
            w.marker.seq  = exp_seq;
            exp_q.push_back(w);
        end
        // Pre-trigger samples, never stored
        for (i = 0; i < rw.pre; i++) begin
            offer_sample(1'b1, s);
        end
        @(posedge wclk);
        trig         <= 1'b1;
        sample_valid <= 1'b0;
        stored = 0;
        for (i = 0; i < rw.post; i++) begin
            valid = rw.gap[i % 8];
            offer_sample(valid, s);
            if (rw.rearm && valid && stored < rw.count) begin
                stored++;
                // FIFO holds 16 words until the host reads
                if (exp_q.size() < DEPTH) begin
                    w = '0;
                    w.sample.chan  = s.chan;
                    w.sample.value = s.value;
                    exp_q.push_back(w);
                end else begin
                    exp_ovf = 1'b1;
                end
            end
        end
        @(posedge wclk);
        sample_valid <= 1'b0;
        trig         <= 1'b0;
        if (rw.rearm) begin
            exp_seq++;
        end
        // Poll for done
        st = '0;
        while (!st.done) begin
            host_read(reg_pkg::REG_STATUS, d);
            st = reg_pkg::status_s'(d[2:0]);
        end
        // Margin for the last pointer crossing
        repeat (2) @(posedge rclk);
        n_read = 0;
        host_read(reg_pkg::REG_STATUS, d);
        st = reg_pkg::status_s'(d[2:0]);
        while (!st.empty) begin
            host_read(reg_pkg::REG_DATA, d);
            assert (n_read < exp_q.size()) else begin
                other_errors++;
                $display("DATA returned a word beyond the expected stream");
            end
            // Stamp is free-running, only kind and seq are compared
            if (n_read < exp_q.size()) begin
                check_value("host_rdata", d, exp_q[n_read],
                            exp_q[n_read][19] ? 20'hFF000 : 20'hFFFFF);
            end
            n_read++;
            host_read(reg_pkg::REG_STATUS, d);
            st = reg_pkg::status_s'(d[2:0]);
        end
        assert (n_read == exp_q.size()) else begin
            other_errors++;
            $display("Read %0d words from DATA, expected %0d", n_read, exp_q.size());
        end
        check_value("STATUS.done", {19'b0, st.done}, 20'h1, 20'hFFFFF);
        check_value("STATUS.overflow", {19'b0, st.overflow}, {19'b0, exp_ovf}, 20'hFFFFF);
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        rrst_n       = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        trig         = 1'b0;
        host_req     = '0;
        seed         = 32'ha23c_765a;
        val_errors   = 0;
        other_errors = 0;
        exp_ovf      = 1'b0;
        exp_seq      = '0;
        // Plain, gapped, overflow, recovery, no re-arm, alternate valid
        rows[0] = '{8'd4,  8'd3, 8'd6,  8'hFF, 1'b1};
        rows[1] = '{8'd5,  8'd2, 8'd12, 8'hB6, 1'b1};
        rows[2] = '{8'd20, 8'd1, 8'd24, 8'hFF, 1'b1};
        rows[3] = '{8'd3,  8'd2, 8'd5,  8'hFF, 1'b1};
        rows[4] = '{8'd3,  8'd2, 8'd5,  8'hFF, 1'b0};
        rows[5] = '{8'd8,  8'd4, 8'd16, 8'h55, 1'b1};
        repeat (10) @(posedge wclk);
        // Release between clock edges
        #3 rrst_n = 1'b1;
        repeat (3) @(posedge rclk);
        host_read(reg_pkg::REG_STATUS, rd);
        check_value("STATUS", rd, 20'h4, 20'hFFFFF);
        host_read(reg_pkg::REG_DATA, rd);
        check_value("host_rdata", rd, 20'h0, 20'hFFFFF);
        for (r = 0; r < N_ROWS; r++) begin
            run_row(rows[r]);
        end
        $display("Errors: %0d value, %0d other", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    // Run limit in wclk cycles
    initial begin
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge wclk);
            cycles++;
        end
        $display("Timeout after %0d wclk cycles, the run did not complete", cycles);
        $display("TEST FAIL");
        $finish;
    end

endmodule

//--- list.f
+incdir+include
src/cap_pkg.sv
src/reg_pkg.sv
src/fifo_wptr_full.sv
src/fifo_rptr_empty.sv
src/fifo_async.sv
src/capture_ctrl.sv
src/host_regs.sv
src/capture_top.sv
bench/capture_tb.sv
